// File: src/fsmc_pkg.sv
// ========================================
// fsmc peripheral shared definitions
// bus widths, address fields, register map and enums
// ========================================
package fsmc_pkg;

    // bus and data widths
    localparam int AD_WIDTH   = 18;
    localparam int DATA_WIDTH = 16;

    // address bits 17..12 must carry this code
    localparam logic [5:0] BANK_CODE = 6'b010000;

    // unit number in bits 11..10, offset in bits 3..0
    localparam int UNIT_LSB     = 10;
    localparam int OFFSET_WIDTH = 4;

    // identification word in status unit
    localparam logic [DATA_WIDTH-1:0] ID_CODE = 16'hF5C1;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_t;

    typedef enum logic [2:0] {
        BUS_IDLE,
        BUS_ADDR,
        BUS_WRITE,
        BUS_READ,
        BUS_HOLD
    } bus_state_t;

    // unit 0 offsets, duties follow REG_DUTY0 back to back
    typedef enum logic [OFFSET_WIDTH-1:0] {
        REG_CTRL   = 4'd0,
        REG_PERIOD = 4'd1,
        REG_DUTY0  = 4'd2
    } reg_offset_t;

    // unit 1 offsets share the encoding space of unit 0
    localparam reg_offset_t STAT_ID    = reg_offset_t'(4'd0);
    localparam reg_offset_t STAT_COUNT = reg_offset_t'(4'd1);

endpackage

// File: src/fsmc_bus_slave.sv
`timescale 1ns/1ps
// ========================================
// fsmc bus slave
// samples the multiplexed ad bus, decodes the unit select,
// pulses register writes and drives read data back
// ========================================
module fsmc_bus_slave #(
    parameter int DATA_HOLD_CYCLES = 2
) (
    input  logic                              clk,
    input  logic                              reset_n,
    inout  wire  [fsmc_pkg::AD_WIDTH-1:0]     ad,
    input  logic                              nadv,
    input  logic                              nwe,
    input  logic                              noe,
    output logic [3:0]                        sel,
    output logic [fsmc_pkg::OFFSET_WIDTH-1:0] reg_offset,
    output logic                              wr_strobe,
    output logic [fsmc_pkg::DATA_WIDTH-1:0]   wr_data,
    input  logic [fsmc_pkg::DATA_WIDTH-1:0]   rd_data
);
    import fsmc_pkg::*;

    // units that answer on the bus
    // 2 and 3 stay silent
    localparam logic [3:0] LIVE_UNITS = 4'b0011;
    localparam int         HOLD_W     = $clog2(DATA_HOLD_CYCLES + 1);

    // ========================================
    // strobe synchronizers and edge detect
    // ========================================
    // bit 0 and 1 are the two sync flops, bit 2 the previous value
    logic [2:0] nadv_sync;
    logic [2:0] nwe_sync;
    logic [2:0] noe_sync;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            // strobes idle high
            nadv_sync <= 3'b111;
            nwe_sync  <= 3'b111;
            noe_sync  <= 3'b111;
        end else begin
            nadv_sync <= {nadv_sync[1:0], nadv};
            nwe_sync  <= {nwe_sync[1:0], nwe};
            noe_sync  <= {noe_sync[1:0], noe};
        end
    end

    logic nadv_rise;
    logic nadv_fall;
    logic nwe_rise;
    logic noe_rise;

    assign nadv_rise = nadv_sync[1] & ~nadv_sync[2];
    assign nadv_fall = ~nadv_sync[1] & nadv_sync[2];
    assign nwe_rise  = nwe_sync[1] & ~nwe_sync[2];
    assign noe_rise  = noe_sync[1] & ~noe_sync[2];

    // ad delayed to line up with the strobe pipeline
    // stage 2 holds the bus as seen while the strobe was still low
    logic [AD_WIDTH-1:0] ad_pipe [3];

    always_ff @(posedge clk) begin
        ad_pipe[0] <= ad;
        ad_pipe[1] <= ad_pipe[0];
        ad_pipe[2] <= ad_pipe[1];
    end

    // ========================================
    // address decode
    // ========================================
    logic       bank_hit;
    logic [1:0] unit;
    logic [3:0] sel_next;
    logic       live;

    always_comb begin
        bank_hit = (ad_pipe[2][AD_WIDTH-1 -: 6] == BANK_CODE);
        unit     = ad_pipe[2][UNIT_LSB +: 2];
        // one-hot unit or nothing on a bank miss
        sel_next = bank_hit ? (4'b0001 << unit) : 4'b0000;
        live     = |(sel_next & LIVE_UNITS);
    end

    // ========================================
    // bus FSM
    // ========================================
    bus_state_t        state;
    op_t               op_q;
    logic              drive_en;
    logic [HOLD_W-1:0] hold_cnt;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= BUS_IDLE;
            op_q       <= OP_READ;
            sel        <= '0;
            reg_offset <= '0;
            wr_strobe  <= 1'b0;
            drive_en   <= 1'b0;
            hold_cnt   <= '0;
        end else begin
            wr_strobe <= 1'b0;
            if (nadv_rise) begin
                // new address phase overrides any open transfer
                sel        <= sel_next;
                reg_offset <= ad_pipe[2][OFFSET_WIDTH-1:0];
                op_q       <= nwe_sync[1] ? OP_READ : OP_WRITE;
                drive_en   <= 1'b0;
                if (!live)
                    state <= BUS_IDLE;
                else if (!nwe_sync[1])
                    state <= BUS_WRITE;
                else
                    state <= BUS_READ;
            end else if (nadv_fall) begin
                state    <= BUS_ADDR;
                drive_en <= 1'b0;
            end else begin
                case (state)
                    BUS_WRITE: begin
                        // single pulse on the nwe rise
                        if (nwe_rise) begin
                            wr_strobe <= 1'b1;
                            state     <= BUS_IDLE;
                        end
                    end
                    BUS_READ: begin
                        if (noe_rise) begin
                            state    <= BUS_HOLD;
                            hold_cnt <= HOLD_W'(DATA_HOLD_CYCLES - 1);
                        end else if (!noe_sync[1]) begin
                            drive_en <= 1'b1;
                        end
                    end
                    BUS_HOLD: begin
                        // keep data on the pins a little past noe
                        if (hold_cnt == '0) begin
                            drive_en <= 1'b0;
                            state    <= BUS_IDLE;
                        end else begin
                            hold_cnt <= hold_cnt - 1'b1;
                        end
                    end
                    default: drive_en <= 1'b0;
                endcase
            end
        end
    end

    // ========================================
    // data capture and read drive
    // ========================================
    logic [DATA_WIDTH-1:0] out_q;

    always_ff @(posedge clk) begin
        if (state == BUS_WRITE && nwe_rise)
            wr_data <= ad_pipe[2][DATA_WIDTH-1:0];
        // frozen once the hold phase starts
        if (state == BUS_READ)
            out_q <= rd_data;
    end

    assign ad = drive_en ? {{(AD_WIDTH - DATA_WIDTH){1'b0}}, out_q} : {AD_WIDTH{1'bz}};

    // decoded select never names two units
    a_sel_onehot: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0(sel));

    // bus is only driven for an access latched as a read
    a_no_drive_on_write: assert property (@(posedge clk) disable iff (!reset_n)
        drive_en |-> op_q == OP_READ);

endmodule

// File: src/fsmc_reg_bank.sv
`timescale 1ns/1ps
// ========================================
// fsmc register bank
// control registers in unit 0, status words in unit 1
// ========================================
module fsmc_reg_bank #(
    parameter int N_CHANNELS = 4
) (
    input  logic                                             clk,
    input  logic                                             reset_n,
    input  logic [3:0]                                       sel,
    input  logic [fsmc_pkg::OFFSET_WIDTH-1:0]                reg_offset,
    input  logic                                             wr_strobe,
    input  logic [fsmc_pkg::DATA_WIDTH-1:0]                  wr_data,
    output logic [fsmc_pkg::DATA_WIDTH-1:0]                  rd_data,
    input  logic [fsmc_pkg::DATA_WIDTH-1:0]                  count,
    output logic [N_CHANNELS-1:0]                            chan_enable,
    output logic [fsmc_pkg::DATA_WIDTH-1:0]                  period,
    output logic [N_CHANNELS-1:0][fsmc_pkg::DATA_WIDTH-1:0]  duty
);
    import fsmc_pkg::*;

    // ========================================
    // unit 0 write decode
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            chan_enable <= '0;
            period      <= '0;
            duty        <= '0;
        end else if (wr_strobe && sel[0]) begin
            case (reg_offset)
                REG_CTRL:   chan_enable <= wr_data[N_CHANNELS-1:0];
                REG_PERIOD: period      <= wr_data;
                default: begin
                    // duty block, anything past the last channel is dropped
                    for (int i = 0; i < N_CHANNELS; i++) begin
                        if (reg_offset == OFFSET_WIDTH'(REG_DUTY0 + i))
                            duty[i] <= wr_data;
                    end
                end
            endcase
        end
    end

    // ========================================
    // read-back mux
    // ========================================
    always_comb begin
        rd_data = '0;
        if (sel[0]) begin
            case (reg_offset)
                REG_CTRL:   rd_data[N_CHANNELS-1:0] = chan_enable;
                REG_PERIOD: rd_data = period;
                default: begin
                    for (int i = 0; i < N_CHANNELS; i++) begin
                        if (reg_offset == OFFSET_WIDTH'(REG_DUTY0 + i))
                            rd_data = duty[i];
                    end
                end
            endcase
        end else if (sel[1]) begin
            // status unit is read only
            case (reg_offset)
                STAT_ID:    rd_data = ID_CODE;
                STAT_COUNT: rd_data = count;
                default:    rd_data = '0;
            endcase
        end
        // units 2 and 3 fall through as zero
    end

    // a write pulse only ever lands on a single unit
    a_wr_single_unit: assert property (@(posedge clk) disable iff (!reset_n)
        wr_strobe |-> $onehot0(sel));

endmodule

// File: src/pwm_channels.sv
`timescale 1ns/1ps
// ========================================
// pwm channels
// one shared period counter, compare output per channel
// ========================================
module pwm_channels #(
    parameter int N_CHANNELS = 4
) (
    input  logic                                             clk,
    input  logic                                             reset_n,
    input  logic [N_CHANNELS-1:0]                            chan_enable,
    input  logic [fsmc_pkg::DATA_WIDTH-1:0]                  period,
    input  logic [N_CHANNELS-1:0][fsmc_pkg::DATA_WIDTH-1:0]  duty,
    output logic [fsmc_pkg::DATA_WIDTH-1:0]                  count,
    output logic [N_CHANNELS-1:0]                            pwm_out
);
    import fsmc_pkg::*;

    logic [DATA_WIDTH-1:0] next_count;

    // ========================================
    // shared counter
    // ========================================
    always_comb begin
        // parked at zero with no period
        // also wraps early if period shrinks below count
        if (period == '0 || count >= period)
            next_count = '0;
        else
            next_count = count + 1'b1;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            count <= '0;
        else
            count <= next_count;
    end

    // ========================================
    // compare outputs
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pwm_out <= '0;
        end else begin
            // high while count is under duty
            for (int i = 0; i < N_CHANNELS; i++)
                pwm_out[i] <= chan_enable[i] && (count < duty[i]);
        end
    end

endmodule

// File: src/fsmc_periph_top.sv
`timescale 1ns/1ps
// ========================================
// fsmc pwm peripheral top
// bus slave, register bank and pwm block
// ========================================
module fsmc_periph_top #(
    parameter int N_CHANNELS       = 4,
    parameter int DATA_HOLD_CYCLES = 2
) (
    input  logic                          clk,
    input  logic                          reset_n,
    inout  wire  [fsmc_pkg::AD_WIDTH-1:0] ad,
    input  logic                          nadv,
    input  logic                          nwe,
    input  logic                          noe,
    output logic [N_CHANNELS-1:0]         pwm_out
);
    import fsmc_pkg::*;

    // bus side
    logic [3:0]              sel;
    logic [OFFSET_WIDTH-1:0] reg_offset;
    logic                    wr_strobe;
    logic [DATA_WIDTH-1:0]   wr_data;
    logic [DATA_WIDTH-1:0]   rd_data;

    // register to pwm
    logic [N_CHANNELS-1:0]                  chan_enable;
    logic [DATA_WIDTH-1:0]                  period;
    logic [N_CHANNELS-1:0][DATA_WIDTH-1:0]  duty;
    logic [DATA_WIDTH-1:0]                  count;

    fsmc_bus_slave #(
        .DATA_HOLD_CYCLES (DATA_HOLD_CYCLES)
    ) u_bus_slave (
        .clk        (clk),
        .reset_n    (reset_n),
        .ad         (ad),
        .nadv       (nadv),
        .nwe        (nwe),
        .noe        (noe),
        .sel        (sel),
        .reg_offset (reg_offset),
        .wr_strobe  (wr_strobe),
        .wr_data    (wr_data),
        .rd_data    (rd_data)
    );

    fsmc_reg_bank #(
        .N_CHANNELS (N_CHANNELS)
    ) u_reg_bank (
        .clk         (clk),
        .reset_n     (reset_n),
        .sel         (sel),
        .reg_offset  (reg_offset),
        .wr_strobe   (wr_strobe),
        .wr_data     (wr_data),
        .rd_data     (rd_data),
        .count       (count),
        .chan_enable (chan_enable),
        .period      (period),
        .duty        (duty)
    );

    pwm_channels #(
        .N_CHANNELS (N_CHANNELS)
    ) u_pwm (
        .clk         (clk),
        .reset_n     (reset_n),
        .chan_enable (chan_enable),
        .period      (period),
        .duty        (duty),
        .count       (count),
        .pwm_out     (pwm_out)
    );

endmodule

// File: testbench/tb_fsmc_periph_top.sv
`timescale 1ns/1ps
// ========================================
// testbench for the fsmc pwm peripheral
// host bus cycles, register checks and pwm output counts
// ========================================
module tb_fsmc_periph_top;
    import fsmc_pkg::*;

    localparam int N_CH           = 4;
    localparam int HOLD_CYCLES    = 2;
    localparam int DRIVE_DELAY    = 2;
    localparam int PWM_PERIOD     = 9;
    localparam int TIMEOUT_CYCLES = 6000;
    // what the pullup leaves on the low half when nobody drives
    localparam logic [DATA_WIDTH-1:0] PULL_WORD = {DATA_WIDTH{1'b1}};

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic                  nadv;
    logic                  nwe;
    logic                  noe;
    logic [N_CH-1:0]       pwm_out;
    wire  [AD_WIDTH-1:0]   ad;
    logic [AD_WIDTH-1:0]   tb_ad;
    logic                  tb_drive;
    logic [31:0]           lcg_state;
    logic [DATA_WIDTH-1:0] period_written;
    int                    errors = 0;
    int                    cycle_count = 0;

    // host side of the shared bus, weak pull when released
    assign ad = tb_drive ? tb_ad : {AD_WIDTH{1'bz}};
    pullup ad_pullup (ad);

    fsmc_periph_top #(
        .N_CHANNELS       (N_CH),
        .DATA_HOLD_CYCLES (HOLD_CYCLES)
    ) u_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .ad      (ad),
        .nadv    (nadv),
        .nwe     (nwe),
        .noe     (noe),
        .pwm_out (pwm_out)
    );

    always #20 clk = ~clk;

    // run limit, well above the length of all tests
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // ========================================
    // helpers and compare tasks
    // ========================================
    function logic [DATA_WIDTH-1:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // bank in 17..12, unit in 11..10, offset in 3..0
    function automatic logic [AD_WIDTH-1:0] make_addr(input logic [5:0] bank,
                                                      input logic [1:0] unit,
                                                      input logic [OFFSET_WIDTH-1:0] offset);
        return {bank, unit, 6'b000000, offset};
    endfunction

    function automatic logic [OFFSET_WIDTH-1:0] duty_offset(input int ch);
        return OFFSET_WIDTH'(REG_DUTY0 + ch);
    endfunction

    task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    // ========================================
    // host bus cycles
    // ========================================
    task automatic bus_write(input logic [AD_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
        tb_ad    = addr;
        tb_drive = 1'b1;
        nadv     = 1'b0;
        idle_cycles(4);
        // nwe low before the nadv rise marks a write
        nwe = 1'b0;
        idle_cycles(4);
        nadv = 1'b1;
        idle_cycles(4);
        tb_ad = {{(AD_WIDTH - DATA_WIDTH){1'b0}}, data};
        idle_cycles(4);
        nwe = 1'b1;
        // data held past the synchronized nwe rise
        idle_cycles(6);
        tb_drive = 1'b0;
        idle_cycles(2);
    endtask

    task automatic bus_read(input logic [AD_WIDTH-1:0] addr, output logic [DATA_WIDTH-1:0] data);
        tb_ad    = addr;
        tb_drive = 1'b1;
        nadv     = 1'b0;
        idle_cycles(4);
        nadv = 1'b1;
        idle_cycles(3);
        tb_drive = 1'b0;
        noe      = 1'b0;
        idle_cycles(8);
        // sample just before noe goes back high
        data = ad[DATA_WIDTH-1:0];
        noe  = 1'b1;
        idle_cycles(HOLD_CYCLES + 4);
        check_bit("ad released", ad == {AD_WIDTH{1'b1}}, 1'b1);
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic test_reset_values();
        logic [DATA_WIDTH-1:0] data;
        bus_read(make_addr(BANK_CODE, 2'd1, STAT_ID), data);
        check_word("stat_id", data, ID_CODE);
        bus_read(make_addr(BANK_CODE, 2'd0, REG_CTRL), data);
        check_word("reg_ctrl", data, 16'h0000);
        bus_read(make_addr(BANK_CODE, 2'd0, REG_PERIOD), data);
        check_word("reg_period", data, 16'h0000);
        for (int ch = 0; ch < N_CH; ch++) begin
            bus_read(make_addr(BANK_CODE, 2'd0, duty_offset(ch)), data);
            check_word($sformatf("reg_duty%0d", ch), data, 16'h0000);
        end
    endtask

    task automatic test_write_readback();
        logic [DATA_WIDTH-1:0] written [N_CH];
        logic [DATA_WIDTH-1:0] data;
        period_written = next_random();
        bus_write(make_addr(BANK_CODE, 2'd0, REG_PERIOD), period_written);
        for (int ch = 0; ch < N_CH; ch++) begin
            written[ch] = next_random();
            bus_write(make_addr(BANK_CODE, 2'd0, duty_offset(ch)), written[ch]);
        end
        bus_read(make_addr(BANK_CODE, 2'd0, REG_PERIOD), data);
        check_word("reg_period", data, period_written);
        for (int ch = 0; ch < N_CH; ch++) begin
            bus_read(make_addr(BANK_CODE, 2'd0, duty_offset(ch)), data);
            check_word($sformatf("reg_duty%0d", ch), data, written[ch]);
        end
    endtask

    task automatic test_unclaimed_access();
        logic [DATA_WIDTH-1:0] data;
        // bank miss aimed at the period register
        bus_write(make_addr(6'b100001, 2'd0, REG_PERIOD), next_random());
        bus_read(make_addr(6'b100001, 2'd0, REG_PERIOD), data);
        check_word("ad wrong bank", data, PULL_WORD);
        // unmapped units
        for (int u = 2; u < 4; u++) begin
            bus_write(make_addr(BANK_CODE, 2'(u), REG_PERIOD), next_random());
            bus_read(make_addr(BANK_CODE, 2'(u), REG_PERIOD), data);
            check_word($sformatf("ad unit%0d", u), data, PULL_WORD);
        end
        bus_read(make_addr(BANK_CODE, 2'd0, REG_PERIOD), data);
        check_word("reg_period", data, period_written);
    endtask

    task automatic test_pwm_outputs();
        logic [DATA_WIDTH-1:0] duties [N_CH] = '{16'd0, 16'd3, 16'd10, 16'd7};
        int                    high_cnt [N_CH];
        int                    exp_cnt;
        bus_write(make_addr(BANK_CODE, 2'd0, REG_PERIOD), 16'(PWM_PERIOD));
        for (int ch = 0; ch < N_CH; ch++)
            bus_write(make_addr(BANK_CODE, 2'd0, duty_offset(ch)), duties[ch]);
        bus_write(make_addr(BANK_CODE, 2'd0, REG_CTRL), 16'h000F);
        idle_cycles(2);
        // one full period of period+1 cycles
        for (int ch = 0; ch < N_CH; ch++)
            high_cnt[ch] = 0;
        for (int cyc = 0; cyc <= PWM_PERIOD; cyc++) begin
            for (int ch = 0; ch < N_CH; ch++)
                if (pwm_out[ch])
                    high_cnt[ch]++;
            idle_cycles(1);
        end
        for (int ch = 0; ch < N_CH; ch++) begin
            exp_cnt = (int'(duties[ch]) < PWM_PERIOD + 1) ? int'(duties[ch]) : PWM_PERIOD + 1;
            check_count($sformatf("pwm_out%0d high cycles", ch), high_cnt[ch], exp_cnt);
        end
        // disabled channels stay low
        bus_write(make_addr(BANK_CODE, 2'd0, REG_CTRL), 16'h0000);
        idle_cycles(2);
        for (int cyc = 0; cyc <= PWM_PERIOD; cyc++) begin
            for (int ch = 0; ch < N_CH; ch++)
                check_bit($sformatf("pwm_out%0d", ch), pwm_out[ch], 1'b0);
            idle_cycles(1);
        end
    endtask

    task automatic test_status_count();
        logic [DATA_WIDTH-1:0] data;
        repeat (2) begin
            bus_read(make_addr(BANK_CODE, 2'd1, STAT_COUNT), data);
            check_bit("stat_count within period", data <= 16'(PWM_PERIOD), 1'b1);
        end
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        reset_n   = 1'b0;
        nadv      = 1'b1;
        nwe       = 1'b1;
        noe       = 1'b1;
        tb_ad     = '0;
        tb_drive  = 1'b0;
        lcg_state = 32'h8358;
        period_written = '0;
        repeat (3) @(posedge clk);
        #(DRIVE_DELAY);
        reset_n = 1'b1;
        idle_cycles(2);
        test_reset_values();
        test_write_readback();
        test_unclaimed_access();
        test_pwm_outputs();
        test_status_count();
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: fsmc_periph_top.f
src/fsmc_pkg.sv
src/fsmc_bus_slave.sv
src/fsmc_reg_bank.sv
src/pwm_channels.sv
src/fsmc_periph_top.sv
testbench/tb_fsmc_periph_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fsmc peripheral testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fsmc_periph_top -Mdir obj_dir -f fsmc_periph_top.f \
    && ./obj_dir/Vtb_fsmc_periph_top | tee /dev/stderr | grep -qx "Testbench passed" \
    && { echo "simulation PASS"; exit 0; } \
    || { echo "simulation FAIL"; exit 1; }
